// File: rtl/aluPkg.sv
// ALU types and constants
package aluPkg;

	localparam int DATA_WIDTH = 16;

	typedef logic [DATA_WIDTH-1:0] dataT; // Operand and result word
	typedef logic [3:0] shamtT;           // Shift amount from the low bits of operand B
	typedef logic [2:0] flagsT;           // Flag values or write mask

	// Flag bit positions
	localparam int FLAG_Z = 0;
	localparam int FLAG_N = 1;
	localparam int FLAG_V = 2;

	// Saturation limits for the 16-bit signed add/subtract
	localparam dataT SAT_POS = 16'h7FFF;
	localparam dataT SAT_NEG = 16'h8000;

	// Opcode encoding with the shift modes in the low two bits
	typedef enum logic [2:0] {
		OP_ADD    = 3'd0,
		OP_SUB    = 3'd1,
		OP_XOR    = 3'd2,
		OP_RED    = 3'd3,
		OP_SLL    = 3'd4,
		OP_SRA    = 3'd5,
		OP_ROR    = 3'd6,
		OP_PADDSB = 3'd7
	} aluOpT;

endpackage

// File: rtl/regPkg.sv
// Register file types
package regPkg;

	localparam int NUM_REGS = 16;
	localparam int REG_ADDR_WIDTH = $clog2(NUM_REGS);

	// Register index where entry 0 is the zero register
	typedef logic [REG_ADDR_WIDTH-1:0] regAddrT;

endpackage

// File: rtl/claAdder.sv
// Four-bit carry-lookahead slice
module claAdder (
	input  logic [3:0] a,
	input  logic [3:0] b,
	input  logic       cin,
	output logic [3:0] sum,
	output logic       cout,
	output logic       ovfl
);

	logic [3:0] g; // Generate per bit
	logic [3:0] p; // Propagate per bit
	logic [4:0] c; // Carries into each bit plus c[4] out

	assign g = a & b;
	assign p = a ^ b;

	// Flattened lookahead without ripple inside the slice
	assign c[0] = cin;
	assign c[1] = g[0] | (p[0] & c[0]);
	assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
	assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
		| (p[2] & p[1] & p[0] & c[0]);
	assign c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]) | (p[3] & p[2] & p[1] & p[0] & c[0]);

	assign sum  = p ^ c[3:0];
	assign cout = c[4];
	assign ovfl = c[4] ^ c[3]; // Carry into and out of sign bit disagree

endmodule

// File: rtl/arithUnit.sv
// Saturating adder, PADDSB and RED
module arithUnit import aluPkg::*; (
	input  dataT aIn,
	input  dataT bIn,
	input  logic sub,
	output dataT sumSat,
	output logic rawZero,
	output logic sign,
	output logic ovfl,
	output dataT paddsb,
	output dataT red
);

	dataT       bEff;      // B or its complement
	dataT       rawSum;    // Unsaturated sum
	logic [4:0] chain;     // Carries between add slices
	logic [3:0] sliceOvfl; // Only the top slice matters

	logic [1:0][8:0] halfSum; // Byte-half total per operand
	logic [9:0]      redTotal;

	// Two's complement subtract inverts B and carries in one
	assign bEff     = bIn ^ {DATA_WIDTH{sub}};
	assign chain[0] = sub;

	for (genvar i = 0; i < 4; i++) begin : gAddSub
		claAdder addSlice (
			.a    (aIn[4*i +: 4]),
			.b    (bEff[4*i +: 4]),
			.cin  (chain[i]),
			.sum  (rawSum[4*i +: 4]),
			.cout (chain[i+1]),
			.ovfl (sliceOvfl[i])
		);
	end

	assign ovfl    = sliceOvfl[3];
	assign sign    = rawSum[15] ^ ovfl; // True sign corrected on overflow
	assign rawZero = ~|rawSum;          // Zero before saturation
	assign sumSat  = ovfl ? (sign ? SAT_NEG : SAT_POS) : rawSum;

	// PADDSB over four independent nibble lanes
	for (genvar i = 0; i < 4; i++) begin : gPaddsb
		logic [3:0] nibRaw;
		logic       nibCout;
		logic       nibOvfl;

		claAdder nibSlice (
			.a    (aIn[4*i +: 4]),
			.b    (bIn[4*i +: 4]),
			.cin  (1'b0),
			.sum  (nibRaw),
			.cout (nibCout),
			.ovfl (nibOvfl)
		);

		// Carry out set means both inputs negative
		assign paddsb[4*i +: 4] = nibOvfl ? (nibCout ? 4'b1000 : 4'b0111) : nibRaw;
	end

	// RED adds the high and low byte of each operand unsigned
	for (genvar j = 0; j < 2; j++) begin : gRedOp
		dataT       opWord;
		logic [2:0] redC;

		assign opWord  = (j == 0) ? aIn : bIn;
		assign redC[0] = 1'b0;

		for (genvar k = 0; k < 2; k++) begin : gRedSlice
			claAdder redSlice (
				.a    (opWord[4*k +: 4]),
				.b    (opWord[8+4*k +: 4]),
				.cin  (redC[k]),
				.sum  (halfSum[j][4*k +: 4]),
				.cout (redC[k+1]),
				.ovfl ()
			);
		end

		assign halfSum[j][8] = redC[2]; // Ninth bit of the byte total
	end

	assign redTotal = {1'b0, halfSum[0]} + {1'b0, halfSum[1]};
	assign red      = {{(DATA_WIDTH-10){redTotal[9]}}, redTotal}; // Sign extend

endmodule

// File: rtl/shifter.sv
// Logarithmic barrel shifter
module shifter import aluPkg::*; (
	input  dataT       shiftIn,
	input  shamtT      shamt,
	input  logic [1:0] mode,
	output dataT       shiftOut
);

	dataT stage; // Running value through the four stages

	// Stage i moves by 2**i when its amount bit is set
	always_comb begin
		stage = shiftIn;
		for (int i = 0; i < 4; i++) begin
			if (shamt[i]) begin
				case (mode)
					2'b00:   stage = stage << (1 << i);                       // SLL
					2'b01:   stage = dataT'($signed(stage) >>> (1 << i));     // SRA
					default: stage = dataT'({stage, stage} >> (1 << i));      // ROR
				endcase
			end
		end
	end

	// Mode 3 is never issued and lands on rotate

	assign shiftOut = stage;

endmodule

// File: rtl/alu.sv
// ALU operation select and flags
module alu import aluPkg::*; (
	input  dataT  aIn,
	input  dataT  bIn,
	input  aluOpT opcode,
	output dataT  aluOut,
	output flagsT flagVal,
	output flagsT flagWe
);

	dataT sumSat;
	dataT paddsb;
	dataT red;
	dataT shiftOut;
	dataT xorOut;
	logic rawZero;
	logic sign;
	logic ovfl;
	logic isAddSub;
	logic isShift;

	assign isAddSub = (opcode == OP_ADD) || (opcode == OP_SUB);
	assign isShift  = opcode inside {OP_SLL, OP_SRA, OP_ROR};
	assign xorOut   = aIn ^ bIn;

	arithUnit arithUnit_inst (
		.aIn     (aIn),
		.bIn     (bIn),
		.sub     (opcode == OP_SUB),
		.sumSat  (sumSat),
		.rawZero (rawZero),
		.sign    (sign),
		.ovfl    (ovfl),
		.paddsb  (paddsb),
		.red     (red)
	);

	shifter shifter_inst (
		.shiftIn  (aIn),
		.shamt    (bIn[3:0]),    // Amount from low bits of B
		.mode     (opcode[1:0]), // 00 SLL, 01 SRA, 10 ROR
		.shiftOut (shiftOut)
	);

	always_comb begin
		case (opcode)
			OP_ADD, OP_SUB:          aluOut = sumSat;
			OP_XOR:                  aluOut = xorOut;
			OP_RED:                  aluOut = red;
			OP_SLL, OP_SRA, OP_ROR:  aluOut = shiftOut;
			default:                 aluOut = paddsb; // OP_PADDSB
		endcase
	end

	// Values always computed and the mask decides what sticks
	assign flagVal[FLAG_Z] = isAddSub ? rawZero : ~|aluOut;
	assign flagVal[FLAG_N] = sign;
	assign flagVal[FLAG_V] = ovfl;

	// ADD and SUB write every flag while XOR and shifts write only Z
	assign flagWe[FLAG_Z] = isAddSub || isShift || (opcode == OP_XOR);
	assign flagWe[FLAG_N] = isAddSub;
	assign flagWe[FLAG_V] = isAddSub;

endmodule

// File: rtl/regFile.sv
// Sixteen-entry register file
module regFile import aluPkg::*, regPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  regAddrT rs,
	input  regAddrT rt,
	output dataT    rsData,
	output dataT    rtData,
	input  logic    wrEn,
	input  regAddrT wrAddr,
	input  dataT    wrData,
	input  logic    loadEn,
	input  regAddrT loadReg,
	input  dataT    loadData
);

	dataT regs [NUM_REGS];

	// Entry 0 is cleared on reset and never written
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 1; i < NUM_REGS; i++) begin
				if (loadEn && loadReg == regAddrT'(i)) begin
					regs[i] <= loadData; // Load wins a same-register clash
				end else if (wrEn && wrAddr == regAddrT'(i)) begin
					regs[i] <= wrData;
				end
			end
		end
	end

	// Unclocked reads see the write one cycle later
	assign rsData = regs[rs];
	assign rtData = regs[rt];

endmodule

// File: rtl/execCore.sv
// Execute stage top level
module execCore import aluPkg::*, regPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  logic    instValid,
	input  aluOpT   opcode,
	input  regAddrT rd,
	input  regAddrT rs,
	input  regAddrT rt,
	input  logic    loadEn,
	input  regAddrT loadReg,
	input  dataT    loadData,
	output dataT    result,
	output logic    resultValid,
	output flagsT   flags
);

	dataT  rsData;
	dataT  rtData;
	dataT  aluOut;
	flagsT flagVal;
	flagsT flagWe;

	regFile regFile_inst (
		.clk      (clk),
		.rstN     (rstN),
		.rs       (rs),
		.rt       (rt),
		.rsData   (rsData),
		.rtData   (rtData),
		.wrEn     (instValid), // Writeback at the issue edge
		.wrAddr   (rd),
		.wrData   (aluOut),
		.loadEn   (loadEn),
		.loadReg  (loadReg),
		.loadData (loadData)
	);

	alu alu_inst (
		.aIn     (rsData),
		.bIn     (rtData),
		.opcode  (opcode),
		.aluOut  (aluOut),
		.flagVal (flagVal),
		.flagWe  (flagWe)
	);

	// Result, valid strobe and flags share the issue edge
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			result      <= '0;
			resultValid <= 1'b0;
			flags       <= '0;
		end else begin
			resultValid <= instValid; // High one cycle per instruction
			if (instValid) begin
				result <= aluOut;
				flags  <= (flags & ~flagWe) | (flagVal & flagWe); // Masked per bit
			end
		end
	end

endmodule

// File: dv/clkGen.sv
// Testbench clock and reset source
module clkGen (
	output logic clk,
	output logic rstN
);

	// 100 unit period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset low for the first two rising edges
	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1; // Released on the edge
	end

endmodule

// File: dv/execCoreTb.sv
// Execute stage testbench
module execCoreTb import aluPkg::*, regPkg::*; ();

	logic    clk;
	logic    rstN;
	logic    instValid;
	aluOpT   opcode;
	regAddrT rd;
	regAddrT rs;
	regAddrT rt;
	logic    loadEn;
	regAddrT loadReg;
	dataT    loadData;
	dataT    result;
	logic    resultValid;
	flagsT   flags;

	// One entry per data line
	string   kindQ [$]; // L load, I instruction, B both in one cycle
	aluOpT   opQ [$];
	regAddrT rdQ [$];
	regAddrT rsQ [$];
	regAddrT rtQ [$];
	dataT    dataQ [$];
	dataT    resQ [$];
	flagsT   flagQ [$];

	int cycleCount = 0;
	int cycleLimit = 1000; // Replaced once the data is read

	clkGen clkGen_inst (
		.clk  (clk),
		.rstN (rstN)
	);

	execCore execCore_inst (
		.clk         (clk),
		.rstN        (rstN),
		.instValid   (instValid),
		.opcode      (opcode),
		.rd          (rd),
		.rs          (rs),
		.rt          (rt),
		.loadEn      (loadEn),
		.loadReg     (loadReg),
		.loadData    (loadData),
		.result      (result),
		.resultValid (resultValid),
		.flags       (flags)
	);

	task automatic readTestData();
		int    fd;
		string line;
		string kind;
		int    op;
		int    dst;
		int    src1;
		int    src2;
		int    dataV;
		int    resV;
		int    flagV;
		fd = $fopen("dv/execCore_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file");
			$display("test failed");
			$fatal(1);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Comment and blank lines fall through the field count
				if (line.len() > 0 && line[0] != "#"
						&& $sscanf(line, "%s %h %h %h %h %h %h %h",
						kind, op, dst, src1, src2, dataV, resV, flagV) == 8) begin
					kindQ.push_back(kind);
					opQ.push_back(aluOpT'(op));
					rdQ.push_back(regAddrT'(dst));
					rsQ.push_back(regAddrT'(src1));
					rtQ.push_back(regAddrT'(src2));
					dataQ.push_back(dataT'(dataV));
					resQ.push_back(dataT'(resV));
					flagQ.push_back(flagsT'(flagV));
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic driveRow(input int i);
		instValid <= (kindQ[i] == "I") || (kindQ[i] == "B");
		loadEn    <= (kindQ[i] == "L") || (kindQ[i] == "B");
		opcode    <= opQ[i];
		rd        <= rdQ[i];
		rs        <= rsQ[i];
		rt        <= rtQ[i];
		loadReg   <= rdQ[i]; // Load always targets the rd column
		loadData  <= dataQ[i];
	endtask

	task automatic driveIdle();
		instValid <= 1'b0;
		loadEn    <= 1'b0;
	endtask

	// Outputs of row i as they stand just before this edge
	task automatic checkRow(input int i);
		checkValue("resultValid", {15'b0, kindQ[i] != "L"}, {15'b0, resultValid});
		if (kindQ[i] != "L") begin
			checkValue("result", resQ[i], result);
		end
		checkValue("flags", {13'b0, flagQ[i]}, {13'b0, flags}); // Running flag state
	endtask

	initial begin
		instValid = 1'b0;
		opcode    = OP_ADD;
		rd        = '0;
		rs        = '0;
		rt        = '0;
		loadEn    = 1'b0;
		loadReg   = '0;
		loadData  = '0;
		readTestData();
		assert (kindQ.size() > 0) else begin
			$display("No rows could be read from the test data file");
			$display("test failed");
			$fatal(1);
		end
		cycleLimit = 2 * kindQ.size() + 20;
		@(posedge rstN);
		@(posedge clk);
		checkValue("result", 16'h0000, result); // Reset state
		checkValue("flags", 16'h0000, {13'b0, flags});
		checkValue("resultValid", 16'h0000, {15'b0, resultValid});
		// Row n issued here and seen two edges later
		for (int n = 0; n < kindQ.size() + 2; n++) begin
			if (n >= 2) begin
				checkRow(n - 2);
			end
			if (n < kindQ.size()) begin
				driveRow(n);
			end else begin
				driveIdle();
			end
			@(posedge clk);
		end
		$display("test passed");
		$finish;
	end

	// Run limit from the data length
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles without reaching the end of the test data",
				cycleLimit);
			$display("test failed");
			$fatal(1);
		end
	end

endmodule

// File: dv/execCore_testdata.txt
# kind op rd rs rt data expResult expFlags, all hex, flags bit0 Z bit1 N bit2 V
# L loads rd with data, I issues op rd rs rt, B does both to rd in one cycle
I 2 3 5 0 0000 0000 1
L 0 1 0 0 7000 0000 1
L 0 2 0 0 2000 0000 1
L 0 4 0 0 8000 0000 1
L 0 5 0 0 0001 0000 1
L 0 6 0 0 FFFF 0000 1
I 0 3 1 2 0000 7FFF 4
I 1 7 4 5 0000 8000 6
I 0 8 5 6 0000 0000 1
I 1 9 2 1 0000 B000 2
I 0 A 4 6 0000 8000 6
I 0 B 4 4 0000 8000 7
L 0 C 0 0 0005 0000 7
L 0 D 0 0 000F 0000 7
L 0 E 0 0 A5C3 0000 7
I 2 F E 6 0000 5A3C 6
I 4 3 E 0 0000 A5C3 6
I 4 3 E 5 0000 4B86 6
I 4 3 E C 0000 B860 6
I 4 3 1 D 0000 0000 7
I 5 3 E 0 0000 A5C3 6
I 5 3 E 5 0000 D2E1 6
I 5 3 E C 0000 FD2E 6
I 5 3 E D 0000 FFFF 6
I 6 3 E 5 0000 D2E1 6
I 6 3 E C 0000 1D2E 6
I 6 3 E D 0000 4B87 6
I 3 3 E 6 0000 FF66 6
I 3 3 5 2 0000 0021 6
L 0 C 0 0 7839 0000 6
L 0 D 0 0 182F 0000 6
I 7 3 C D 0000 7858 6
I 0 2 2 5 0000 2001 0
I 0 2 2 5 0000 2002 0
I 0 2 2 2 0000 4004 0
I 1 2 2 6 0000 4005 0
I 2 2 2 0 0000 4005 0
L 0 0 0 0 1234 0000 0
I 0 3 0 5 0000 0001 0
B 0 9 5 5 5555 0002 0
I 2 3 9 0 0000 5555 0

// File: verilog.f
rtl/aluPkg.sv
rtl/regPkg.sv
rtl/claAdder.sv
rtl/arithUnit.sv
rtl/shifter.sv
rtl/alu.sv
rtl/regFile.sv
rtl/execCore.sv
dv/clkGen.sv
dv/execCoreTb.sv
